/* common/dii_pkg.sv */
// ###################################################################
// Debug flit type, packet type codes, request and response
// word positions and packet lengths
// ###################################################################
package dii_pkg;

   localparam int unsigned FLIT_WIDTH = 16;

   typedef struct packed {
      logic                  last;
      logic [FLIT_WIDTH-1:0] data;
   } dii_flit_t;

   // Carried in the upper 4 bits of word 2
   typedef enum logic [3:0] {
      MEM_READ  = 4'h1,
      MEM_WRITE = 4'h2,
      RST_WRITE = 4'h3,
      RESP_DATA = 4'h8,
      RESP_ACK  = 4'h9,
      RESP_ERR  = 4'hA
   } pkt_type_e;

   // Request words, the RST_WRITE bits sit where address high would be
   localparam logic [2:0] WORD_DEST    = 3'd0;
   localparam logic [2:0] WORD_SRC     = 3'd1;
   localparam logic [2:0] WORD_TYPE    = 3'd2;
   localparam logic [2:0] WORD_ADDR_HI = 3'd3;
   localparam logic [2:0] WORD_ADDR_LO = 3'd4;
   localparam logic [2:0] WORD_DATA_HI = 3'd5;
   localparam logic [2:0] WORD_DATA_LO = 3'd6;

   localparam logic [2:0] LEN_MEM_READ  = 3'd5;
   localparam logic [2:0] LEN_MEM_WRITE = 3'd7;
   localparam logic [2:0] LEN_RST_WRITE = 3'd4;

   localparam int unsigned RST_BIT_CPU = 0;
   localparam int unsigned RST_BIT_SYS = 1;

   // Response words
   localparam logic [2:0] RESP_WORD_REQ     = 3'd0;
   localparam logic [2:0] RESP_WORD_ID      = 3'd1;
   localparam logic [2:0] RESP_WORD_TYPE    = 3'd2;
   localparam logic [2:0] RESP_WORD_DATA_HI = 3'd3;

   localparam logic [2:0] RESP_LEN_DATA  = 3'd5;
   localparam logic [2:0] RESP_LEN_SHORT = 3'd3;

endpackage

/* common/tile_cfg_pkg.sv */
// ###################################################################
// Wishbone widths, request and response structs and the
// decoded debug request
// ###################################################################
package tile_cfg_pkg;

   localparam int unsigned ADDR_WIDTH = 32;
   localparam int unsigned DATA_WIDTH = 32;
   localparam int unsigned SEL_WIDTH  = DATA_WIDTH / 8;

   // Master side of a classic Wishbone cycle
   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [ADDR_WIDTH-1:0] adr;
      logic [DATA_WIDTH-1:0] dat;
      logic [SEL_WIDTH-1:0]  sel;
   } wb_req_t;

   // Slave side
   typedef struct packed {
      logic                  ack;
      logic                  err;
      logic [DATA_WIDTH-1:0] dat;
   } wb_rsp_t;

   // One decoded debug request, reset bits travel in data
   typedef struct packed {
      dii_pkg::pkt_type_e             pkt_type;
      logic [dii_pkg::FLIT_WIDTH-1:0] src;
      logic [ADDR_WIDTH-1:0]          addr;
      logic [DATA_WIDTH-1:0]          data;
   } dbg_req_t;

endpackage

/* dbg/dbg_packet_rx.sv */
// ###################################################################
// Debug packet receiver, assembles flits into one request
// ###################################################################
`timescale 1ns/1ps

module dbg_packet_rx #(
   parameter logic [15:0] DEBUG_ID = 16'd1
) (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  dii_pkg::dii_flit_t     in_flit_i,
   input  logic                   in_valid_i,
   output logic                   in_ready_o,
   output tile_cfg_pkg::dbg_req_t req_o,
   output logic                   req_valid_o,
   input  logic                   req_ready_i
);

   // Counter sticks here for packets longer than any valid layout
   localparam logic [2:0] CNT_MAX = 3'd7;

   logic [2:0]             cnt_q;
   logic                   dest_ok_q;
   logic                   req_valid_q;
   tile_cfg_pkg::dbg_req_t req_q;
   logic                   flit_acc;
   logic                   pkt_ok;

   function automatic logic len_ok(input dii_pkg::pkt_type_e t, input logic [2:0] idx);
      case (t)
         dii_pkg::MEM_READ:  return idx == dii_pkg::LEN_MEM_READ - 3'd1;
         dii_pkg::MEM_WRITE: return idx == dii_pkg::LEN_MEM_WRITE - 3'd1;
         dii_pkg::RST_WRITE: return idx == dii_pkg::LEN_RST_WRITE - 3'd1;
         default:            return 1'b0;
      endcase
   endfunction

   assign in_ready_o  = ~req_valid_q;
   assign flit_acc    = in_valid_i & in_ready_o;
   assign pkt_ok      = dest_ok_q & len_ok(req_q.pkt_type, cnt_q);
   assign req_o       = req_q;
   assign req_valid_o = req_valid_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q       <= '0;
         dest_ok_q   <= 1'b0;
         req_valid_q <= 1'b0;
      end else begin
         if (req_valid_q && req_ready_i) begin
            req_valid_q <= 1'b0;
         end
         if (flit_acc) begin
            if (in_flit_i.last) begin
               // Foreign or malformed packets end here without a request
               cnt_q       <= '0;
               dest_ok_q   <= 1'b0;
               req_valid_q <= pkt_ok;
            end else begin
               if (cnt_q != CNT_MAX) begin
                  cnt_q <= cnt_q + 3'd1;
               end
               if (cnt_q == dii_pkg::WORD_DEST) begin
                  dest_ok_q <= (in_flit_i.data == DEBUG_ID);
               end
            end
         end
      end
   end

   // Field capture by word position
   always_ff @(posedge clk) begin
      if (flit_acc) begin
         case (cnt_q)
            dii_pkg::WORD_SRC:  req_q.src <= in_flit_i.data;
            dii_pkg::WORD_TYPE: req_q.pkt_type <= dii_pkg::pkt_type_e'(in_flit_i.data[15:12]);
            dii_pkg::WORD_ADDR_HI: begin
               if (req_q.pkt_type == dii_pkg::RST_WRITE) begin
                  req_q.data <= {16'h0000, in_flit_i.data};
               end else begin
                  req_q.addr[31:16] <= in_flit_i.data;
               end
            end
            dii_pkg::WORD_ADDR_LO: req_q.addr[15:0] <= in_flit_i.data;
            dii_pkg::WORD_DATA_HI: req_q.data[31:16] <= in_flit_i.data;
            dii_pkg::WORD_DATA_LO: req_q.data[15:0] <= in_flit_i.data;
            default: ;
         endcase
      end
   end

endmodule

/* dbg/dbg_mem_access.sv */
// ###################################################################
// Debug memory access engine with reset register and
// response serializer
// ###################################################################
`timescale 1ns/1ps

module dbg_mem_access #(
   parameter logic [15:0] DEBUG_ID = 16'd1
) (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  tile_cfg_pkg::dbg_req_t req_i,
   input  logic                   req_valid_i,
   output logic                   req_ready_o,
   output tile_cfg_pkg::wb_req_t  wb_req_o,
   input  tile_cfg_pkg::wb_rsp_t  wb_rsp_i,
   output dii_pkg::dii_flit_t     out_flit_o,
   output logic                   out_valid_o,
   input  logic                   out_ready_i,
   output logic                   sys_rst_o,
   output logic                   cpu_rst_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUS,
      ST_RST,
      ST_SEND
   } state_e;

   state_e                                state_q;
   tile_cfg_pkg::dbg_req_t                req_q;
   logic [2:0]                            idx_q;
   logic                                  err_q;
   logic [tile_cfg_pkg::DATA_WIDTH-1:0]   rdata_q;
   logic                                  sys_rst_q;
   logic                                  cpu_rst_q;
   dii_pkg::pkt_type_e                    resp_type;
   logic [2:0]                            resp_last_idx;
   logic                                  bus_done;
   logic                                  flit_sent;

   assign req_ready_o = (state_q == ST_IDLE);
   assign out_valid_o = (state_q == ST_SEND);
   assign bus_done    = wb_rsp_i.ack | wb_rsp_i.err;
   assign flit_sent   = out_valid_o & out_ready_i;
   assign sys_rst_o   = sys_rst_q;
   assign cpu_rst_o   = cpu_rst_q;

   // Single classic cycle, full word lanes
   always_comb begin
      wb_req_o.cyc = (state_q == ST_BUS);
      wb_req_o.stb = (state_q == ST_BUS);
      wb_req_o.we  = (req_q.pkt_type == dii_pkg::MEM_WRITE);
      wb_req_o.adr = req_q.addr;
      wb_req_o.dat = req_q.data;
      wb_req_o.sel = '1;
   end

   // Response type and length follow from the latched outcome
   always_comb begin
      if (err_q) begin
         resp_type = dii_pkg::RESP_ERR;
      end else if (req_q.pkt_type == dii_pkg::MEM_READ) begin
         resp_type = dii_pkg::RESP_DATA;
      end else begin
         resp_type = dii_pkg::RESP_ACK;
      end
      if (resp_type == dii_pkg::RESP_DATA) begin
         resp_last_idx = dii_pkg::RESP_LEN_DATA - 3'd1;
      end else begin
         resp_last_idx = dii_pkg::RESP_LEN_SHORT - 3'd1;
      end
   end

   always_comb begin
      out_flit_o.last = (idx_q == resp_last_idx);
      case (idx_q)
         dii_pkg::RESP_WORD_REQ:     out_flit_o.data = req_q.src;
         dii_pkg::RESP_WORD_ID:      out_flit_o.data = DEBUG_ID;
         dii_pkg::RESP_WORD_TYPE:    out_flit_o.data = {resp_type, 12'h000};
         dii_pkg::RESP_WORD_DATA_HI: out_flit_o.data = rdata_q[31:16];
         default:                    out_flit_o.data = rdata_q[15:0];
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= ST_IDLE;
         idx_q     <= '0;
         err_q     <= 1'b0;
         sys_rst_q <= 1'b0;
         cpu_rst_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (req_valid_i) begin
                  idx_q   <= '0;
                  state_q <= (req_i.pkt_type == dii_pkg::RST_WRITE) ? ST_RST : ST_BUS;
               end
            end
            ST_BUS: begin
               if (bus_done) begin
                  err_q   <= wb_rsp_i.err;
                  state_q <= ST_SEND;
               end
            end
            ST_RST: begin
               cpu_rst_q <= req_q.data[dii_pkg::RST_BIT_CPU];
               sys_rst_q <= req_q.data[dii_pkg::RST_BIT_SYS];
               err_q     <= 1'b0;
               state_q   <= ST_SEND;
            end
            ST_SEND: begin
               if (flit_sent) begin
                  if (out_flit_o.last) begin
                     state_q <= ST_IDLE;
                  end else begin
                     idx_q <= idx_q + 3'd1;
                  end
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid_i && req_ready_o) begin
         req_q <= req_i;
      end
      if (state_q == ST_BUS && wb_rsp_i.ack) begin
         rdata_q <= wb_rsp_i.dat;
      end
   end

endmodule

/* verilog/wb_sram.sv */
// ###################################################################
// Word-addressed Wishbone memory with registered acknowledge
// ###################################################################
`timescale 1ns/1ps

module wb_sram #(
   parameter int unsigned MEM_WORDS = 256
) (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  tile_cfg_pkg::wb_req_t wb_req_i,
   output tile_cfg_pkg::wb_rsp_t wb_rsp_o
);

   localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   logic [tile_cfg_pkg::DATA_WIDTH-1:0] mem_q [MEM_WORDS];
   logic [tile_cfg_pkg::DATA_WIDTH-1:0] rdat_q;
   logic [IDX_W-1:0]                    word_idx;
   logic                                in_range;
   logic                                access;
   logic                                ack_q;
   logic                                err_q;

   // Byte address bits 1:0 are ignored
   assign word_idx = wb_req_i.adr[2 +: IDX_W];
   assign in_range = (wb_req_i.adr[tile_cfg_pkg::ADDR_WIDTH-1:2] < MEM_WORDS);

   // New access only while no ack or err is on the bus
   assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q & ~err_q;

   assign wb_rsp_o = '{ack: ack_q, err: err_q, dat: rdat_q};

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= access & in_range;
         err_q <= access & ~in_range;
      end
   end

   always_ff @(posedge clk) begin
      if (access && in_range) begin
         rdat_q <= mem_q[word_idx];
         if (wb_req_i.we) begin
            for (int b = 0; b < tile_cfg_pkg::SEL_WIDTH; b++) begin
               if (wb_req_i.sel[b]) begin
                  mem_q[word_idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
               end
            end
         end
      end
   end

endmodule

/* verilog/tile_dm_top.sv */
// ###################################################################
// Tile top level: receiver, access engine and memory
// ###################################################################
`timescale 1ns/1ps

module tile_dm_top #(
   parameter logic [15:0] DEBUG_ID  = 16'd1,
   parameter int unsigned MEM_WORDS = 256
) (
   input  logic               clk,
   input  logic               rst_n_i,
   input  dii_pkg::dii_flit_t in_flit_i,
   input  logic               in_valid_i,
   output logic               in_ready_o,
   output dii_pkg::dii_flit_t out_flit_o,
   output logic               out_valid_o,
   input  logic               out_ready_i,
   output logic               sys_rst_o,
   output logic               cpu_rst_o
);

   tile_cfg_pkg::dbg_req_t req;
   logic                   req_valid;
   logic                   req_ready;
   tile_cfg_pkg::wb_req_t  wb_req;
   tile_cfg_pkg::wb_rsp_t  wb_rsp;

   dbg_packet_rx #(
      .DEBUG_ID (DEBUG_ID)
   ) u_rx (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_flit_i   (in_flit_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .req_o       (req),
      .req_valid_o (req_valid),
      .req_ready_i (req_ready)
   );

   dbg_mem_access #(
      .DEBUG_ID (DEBUG_ID)
   ) u_access (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .req_i       (req),
      .req_valid_i (req_valid),
      .req_ready_o (req_ready),
      .wb_req_o    (wb_req),
      .wb_rsp_i    (wb_rsp),
      .out_flit_o  (out_flit_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i),
      .sys_rst_o   (sys_rst_o),
      .cpu_rst_o   (cpu_rst_o)
   );

   // Stands in for the external memory path
   wb_sram #(
      .MEM_WORDS (MEM_WORDS)
   ) u_sram (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .wb_req_i (wb_req),
      .wb_rsp_o (wb_rsp)
   );

endmodule

/* tb/tile_dm_assertions.sv */
// ######################################################################
// Concurrent checks on the Wishbone and response flit handshakes,
// bound into the access engine
// ######################################################################
`timescale 1ns/1ps

module tile_dm_assertions (
   input logic                  clk,
   input logic                  rst_n_i,
   input tile_cfg_pkg::wb_req_t wb_req_i,
   input tile_cfg_pkg::wb_rsp_t wb_rsp_i,
   input dii_pkg::dii_flit_t    flit_i,
   input logic                  valid_i,
   input logic                  ready_i
);

   int unsigned fail_cnt = 0;

   // Classic cycle stays open until the slave answers
   wb_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      (wb_req_i.cyc && wb_req_i.stb && !wb_rsp_i.ack && !wb_rsp_i.err)
      |=> (wb_req_i.cyc && wb_req_i.stb))
      else begin
         fail_cnt++;
         $error("Wishbone cyc or stb dropped before ack or err");
      end

   flit_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      (valid_i && !ready_i) |=> (valid_i && $stable(flit_i)))
      else begin
         fail_cnt++;
         $error("Response flit or valid changed while ready was low");
      end

   // A slave answer only belongs to an open cycle
   wb_rsp_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
      (wb_rsp_i.ack || wb_rsp_i.err) |-> (wb_req_i.cyc && wb_req_i.stb))
      else begin
         fail_cnt++;
         $error("Wishbone ack or err outside an open cycle");
      end

endmodule

bind dbg_mem_access tile_dm_assertions u_assertions (
   .clk      (clk),
   .rst_n_i  (rst_n_i),
   .wb_req_i (wb_req_o),
   .wb_rsp_i (wb_rsp_i),
   .flit_i   (out_flit_o),
   .valid_i  (out_valid_o),
   .ready_i  (out_ready_i)
);

/* tb/tb_tile_dm.sv */
// ######################################################################
// Testbench for the tile: LCG stimulus, reference model, response
// collector and compare process, timeout and final report
// ######################################################################
`timescale 1ns/1ps

module tb_tile_dm;

   localparam logic [15:0] DEBUG_ID   = 16'd1;
   localparam int unsigned MEM_WORDS  = 256;
   localparam int          N_MEM      = 8;
   localparam int          N_BP       = 10;
   // Write/read pairs, out of range, reset, dropped packets, back-pressure
   localparam int          NUM_PKTS   = 2 * N_MEM + 3 + 4 + 4 + N_BP;
   localparam int          MAX_CYCLES = 40 * NUM_PKTS + 100;

   logic               clk = 1'b0;
   logic               rst_n_i;
   dii_pkg::dii_flit_t in_flit_i;
   logic               in_valid_i;
   logic               in_ready_o;
   dii_pkg::dii_flit_t out_flit_o;
   logic               out_valid_o;
   logic               out_ready_i = 1'b1;
   logic               sys_rst_o;
   logic               cpu_rst_o;

   logic [31:0]        stim_seed  = 32'd91926;
   logic [31:0]        stall_seed = 32'd91926;
   logic [31:0]        stall_val;
   logic               stall_en   = 1'b0;
   int                 cycle_cnt  = 0;
   int                 value_errs = 0;
   int                 pkt_errs   = 0;
   int                 assert_errs;

   logic [15:0]        pkt_words[$];
   dii_pkg::dii_flit_t exp_q[$];
   string              exp_name_q[$];
   logic [2:0]         exp_rst_q[$];
   dii_pkg::dii_flit_t got_q[$];
   logic [1:0]         got_rst_q[$];
   logic [31:0]        model_mem [MEM_WORDS];
   logic [1:0]         model_rst = 2'b00;
   logic [31:0]        addr_list[$];
   dii_pkg::dii_flit_t cmp_got;
   logic [1:0]         cmp_rst;
   logic [31:0]        addr;
   logic [31:0]        data;

   tile_dm_top #(
      .DEBUG_ID  (DEBUG_ID),
      .MEM_WORDS (MEM_WORDS)
   ) tile_dm_top_i (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_flit_i   (in_flit_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_flit_o  (out_flit_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i),
      .sys_rst_o   (sys_rst_o),
      .cpu_rst_o   (cpu_rst_o)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] lcg_next(inout logic [31:0] state);
      state = state * 32'd1664525 + 32'd1013904223;
      return state;
   endfunction

   function automatic logic [31:0] rand_addr();
      logic [31:0] r;
      r = lcg_next(stim_seed);
      return (r % MEM_WORDS) << 2;
   endfunction

   // Queues the response words, {check, sys, cpu} rides along with each flit
   function automatic void expect_resp(input string name, input logic [15:0] src,
                                       input logic [3:0] rtyp, input logic [31:0] rdata,
                                       input logic chk_rst);
      logic [15:0]        w[$];
      dii_pkg::dii_flit_t f;
      w.push_back(src);
      w.push_back(DEBUG_ID);
      w.push_back({rtyp, 12'h000});
      if (rtyp == dii_pkg::RESP_DATA) begin
         w.push_back(rdata[31:16]);
         w.push_back(rdata[15:0]);
      end
      foreach (w[i]) begin
         f.last = (i == w.size() - 1);
         f.data = w[i];
         exp_q.push_back(f);
         exp_name_q.push_back(name);
         exp_rst_q.push_back({chk_rst, model_rst});
      end
   endfunction

   // Reference model of one request packet held in pkt_words
   function automatic void model_packet(input string name);
      logic [3:0]  typ;
      logic [31:0] a;
      logic [31:0] d;
      int          len;
      len = pkt_words.size();
      typ = pkt_words[2][15:12];
      if (pkt_words[0] == DEBUG_ID) begin
         if (typ == dii_pkg::MEM_READ && len == 5) begin
            a = {pkt_words[3], pkt_words[4]};
            if (a[31:2] < MEM_WORDS) begin
               expect_resp(name, pkt_words[1], dii_pkg::RESP_DATA, model_mem[a[31:2]], 1'b0);
            end else begin
               expect_resp(name, pkt_words[1], dii_pkg::RESP_ERR, '0, 1'b0);
            end
         end else if (typ == dii_pkg::MEM_WRITE && len == 7) begin
            a = {pkt_words[3], pkt_words[4]};
            d = {pkt_words[5], pkt_words[6]};
            if (a[31:2] < MEM_WORDS) begin
               model_mem[a[31:2]] = d;
               expect_resp(name, pkt_words[1], dii_pkg::RESP_ACK, '0, 1'b0);
            end else begin
               expect_resp(name, pkt_words[1], dii_pkg::RESP_ERR, '0, 1'b0);
            end
         end else if (typ == dii_pkg::RST_WRITE && len == 4) begin
            model_rst = pkt_words[3][1:0];
            expect_resp(name, pkt_words[1], dii_pkg::RESP_ACK, '0, 1'b1);
         end
      end
   endfunction

   // Called and returns 10 ns after a rising edge
   task automatic send_packet(input string name, input logic [15:0] dest,
                              input logic [3:0] typ, input logic [31:0] a,
                              input logic [31:0] d, input int len);
      logic [15:0] fields [7];
      logic [31:0] r;
      logic        acc;
      r = lcg_next(stim_seed);
      // Requester id varies so the echo in word 0 is checked
      fields = '{dest, {8'h40, r[23:16]}, {typ, 12'h000}, a[31:16], a[15:0],
                 d[31:16], d[15:0]};
      pkt_words.delete();
      for (int i = 0; i < len; i++) begin
         pkt_words.push_back(fields[i]);
      end
      model_packet(name);
      foreach (pkt_words[i]) begin
         in_flit_i.last = (i == len - 1);
         in_flit_i.data = pkt_words[i];
         in_valid_i     = 1'b1;
         do begin
            @(negedge clk);
            acc = in_ready_o;
            @(posedge clk);
            #10;
         end while (!acc);
      end
      in_valid_i = 1'b0;
   endtask

   task automatic wait_responses();
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      @(posedge clk);
      #10;
   endtask

   task automatic compare_flit(input string name, input dii_pkg::dii_flit_t exp,
                               input dii_pkg::dii_flit_t got);
      if (got !== exp) begin
         value_errs++;
         $display("FAILED %s: expected flit %h actual %h", name, exp, got);
      end
   endtask

   task automatic compare_rst(input string name, input logic [1:0] exp, input logic [1:0] got);
      if (got !== exp) begin
         value_errs++;
         $display("FAILED %s: expected sys/cpu reset %b actual %b", name, exp, got);
      end
   endtask

   // Random stalls on the response stream
   always @(posedge clk) begin
      #10;
      stall_val   = lcg_next(stall_seed);
      out_ready_i = ~stall_en | stall_val[28] | stall_val[21];
   end

   // Collector, a transfer seen here completes on the next rising edge
   always @(negedge clk) begin
      if (rst_n_i && out_valid_o && out_ready_i) begin
         got_q.push_back(out_flit_o);
         got_rst_q.push_back({sys_rst_o, cpu_rst_o});
      end
   end

   always @(posedge clk) begin
      while (got_q.size() != 0) begin
         cmp_got = got_q.pop_front();
         cmp_rst = got_rst_q.pop_front();
         if (exp_q.size() == 0) begin
            pkt_errs++;
            $display("ERROR: response flit %h arrived with no request expecting it", cmp_got);
         end else begin
            compare_flit(exp_name_q[0], exp_q[0], cmp_got);
            if (exp_q[0].last && exp_rst_q[0][2]) begin
               compare_rst(exp_name_q[0], exp_rst_q[0][1:0], cmp_rst);
            end
            void'(exp_q.pop_front());
            void'(exp_name_q.pop_front());
            void'(exp_rst_q.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > MAX_CYCLES) begin
         $display("ERROR: timeout after %0d cycles with %0d response flits still missing",
                  cycle_cnt, exp_q.size());
         $display("TB FAILED");
         $finish;
      end
   end

   initial begin
      rst_n_i    = 1'b0;
      in_flit_i  = '0;
      in_valid_i = 1'b0;
      repeat (2) @(posedge clk);
      #10;
      rst_n_i = 1'b1;
      @(negedge clk);
      if (in_ready_o !== 1'b1 || out_valid_o !== 1'b0) begin
         value_errs++;
         $display("FAILED reset state: expected ready 1 valid 0 actual ready %b valid %b",
                  in_ready_o, out_valid_o);
      end
      compare_rst("reset state", 2'b00, {sys_rst_o, cpu_rst_o});
      @(posedge clk);
      #10;

      // Write then read back
      for (int i = 0; i < N_MEM; i++) begin
         addr = rand_addr();
         data = lcg_next(stim_seed);
         addr_list.push_back(addr);
         send_packet("write", DEBUG_ID, dii_pkg::MEM_WRITE, addr, data, 7);
         wait_responses();
      end
      foreach (addr_list[i]) begin
         send_packet("read back", DEBUG_ID, dii_pkg::MEM_READ, addr_list[i], '0, 5);
         wait_responses();
      end

      // Out of range, the write address has the same low bits as a stored word
      addr = addr_list[0] + MEM_WORDS * 4;
      send_packet("out of range write", DEBUG_ID, dii_pkg::MEM_WRITE, addr, ~data, 7);
      send_packet("out of range read", DEBUG_ID, dii_pkg::MEM_READ, addr, '0, 5);
      send_packet("read after out of range", DEBUG_ID, dii_pkg::MEM_READ, addr_list[0], '0, 5);
      wait_responses();

      // Reset register, all four bit combinations
      for (int i = 0; i < 4; i++) begin
         send_packet("reset register", DEBUG_ID, dii_pkg::RST_WRITE,
                     {14'd0, 2'(i + 3), 16'h0000}, '0, 4);
         wait_responses();
      end

      // Dropped packets
      send_packet("foreign destination", DEBUG_ID + 16'd1, dii_pkg::MEM_READ,
                  addr_list[1], '0, 5);
      send_packet("unknown type", DEBUG_ID, 4'h7, addr_list[1], '0, 5);
      send_packet("short write", DEBUG_ID, dii_pkg::MEM_WRITE, addr_list[1], 32'h0, 5);
      send_packet("read after dropped", DEBUG_ID, dii_pkg::MEM_READ, addr_list[1], '0, 5);
      wait_responses();

      // Back to back under random stalls
      stall_en = 1'b1;
      for (int i = 0; i < N_BP; i++) begin
         if (i % 2 == 0) begin
            addr = rand_addr();
            data = lcg_next(stim_seed);
            addr_list.push_back(addr);
            send_packet("back-pressure write", DEBUG_ID, dii_pkg::MEM_WRITE, addr, data, 7);
         end else begin
            send_packet("back-pressure read", DEBUG_ID, dii_pkg::MEM_READ,
                        addr_list[addr_list.size() - 1], '0, 5);
         end
      end
      wait_responses();
      stall_en = 1'b0;

      // Room for any extra response flits to show up
      repeat (20) @(posedge clk);
      assert_errs = tile_dm_top_i.u_access.u_assertions.fail_cnt;
      $display("Errors: %0d value, %0d packet, %0d assertion",
               value_errs, pkt_errs, assert_errs);
      if (value_errs + pkt_errs + assert_errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* tile_dm.f */
common/dii_pkg.sv
common/tile_cfg_pkg.sv
dbg/dbg_packet_rx.sv
dbg/dbg_mem_access.sv
verilog/wb_sram.sv
verilog/tile_dm_top.sv
tb/tile_dm_assertions.sv
tb/tb_tile_dm.sv

/* Bender.yml */
package:
  name: tile_dm

sources:
  - files:
      - common/dii_pkg.sv
      - common/tile_cfg_pkg.sv
      - dbg/dbg_packet_rx.sv
      - dbg/dbg_mem_access.sv
      - verilog/wb_sram.sv
      - verilog/tile_dm_top.sv
  - target: test
    files:
      - tb/tile_dm_assertions.sv
      - tb/tb_tile_dm.sv
